// File: common/l2_coh_pkg.sv
// coherence states, bus commands and request opcodes shared by the pipeline and snoop logic
package l2_coh_pkg;

  localparam int bus_id_w = 2;

  typedef enum logic [2:0] {
    state_i = 3'd0,
    state_s = 3'd1,
    state_f = 3'd2,
    state_m = 3'd3
  } coh_state_e;

  // upgr and flush are never issued here but still show up on the bus
  typedef enum logic [2:0] {
    cmd_busrd   = 3'd0,
    cmd_busrdx  = 3'd1,
    cmd_busupgr = 3'd2,
    cmd_fill    = 3'd3,
    cmd_flush   = 3'd4
  } bus_cmd_e;

  // bit 1 set means write
  typedef enum logic [1:0] {
    op_rd = 2'b00,
    op_wr = 2'b10
  } req_op_e;

  typedef logic [2:0] xact_tag_t;

endpackage

// File: common/l2_geom_pkg.sv
// cache geometry and address-field types, imported by every tag-side module
package l2_geom_pkg;

  localparam int num_sets = 512;
  localparam int num_ways = 4;

  // set index is address bits 14..6
  typedef logic [8:0] set_idx_t;
  // tag is address bits 31..15
  typedef logic [16:0] line_tag_t;
  // line address is address bits 31..6
  typedef logic [25:0] line_addr_t;
  typedef logic [num_ways-1:0] way_oh_t;
  // bit 2 picks the half, 0 means ways 0 and 1
  // bit 0 picks within ways 0 and 1, bit 1 within ways 2 and 3
  typedef logic [2:0] lru_t;

  function automatic set_idx_t set_of(line_addr_t addr);
    return addr[8:0];
  endfunction

  function automatic line_tag_t tag_of(line_addr_t addr);
    return addr[25:9];
  endfunction

  function automatic logic [1:0] way_idx(way_oh_t way);
    return {way[3] | way[2], way[3] | way[1]};
  endfunction

endpackage

// File: hdl/l2tag.sv
// L2 tag side top level, connects the request pipeline, snoop unit and tag array
`timescale 1ns/1ps

module l2tag
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
#(
  parameter logic [bus_id_w-1:0] bus_id = 2'd1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid,
  input  req_op_e     req_op,
  input  logic [31:2] req_addr,
  input  logic [3:0]  req_wmask,
  input  logic [31:0] req_wdata,
  output logic        l2_req_ready,
  input  logic        bus_valid,
  input  bus_cmd_e    bus_cmd,
  input  logic [4:0]  bus_tag,
  input  line_addr_t  bus_addr,
  input  logic [63:0] bus_data,
  output logic        l2tag_req_valid,
  output req_op_e     l2tag_req_op,
  output logic        l2tag_req_cmd_valid,
  output bus_cmd_e    l2tag_req_cmd,
  output logic [31:3] l2tag_req_addr,
  output way_oh_t     l2tag_req_way,
  output logic [7:0]  l2tag_req_wmask,
  output logic [63:0] l2tag_req_wdata,
  input  logic        l2data_req_ready,
  output logic        l2tag_fill_valid,
  output line_addr_t  l2tag_fill_addr,
  output way_oh_t     l2tag_fill_way,
  output logic [63:0] l2tag_fill_wdata,
  input  logic        l2trans_valid,
  input  xact_tag_t   l2trans_tag,
  output logic        l2_bus_hit
);

  logic                snoop_s0_valid;
  line_addr_t          snoop_s0_addr;
  logic                snp_s1_valid;
  logic                fill;
  logic                snp_state_wen;
  coh_state_e          snp_state_wdata;
  line_addr_t          snp_addr;
  logic                req_lookup_en;
  line_addr_t          req_s0_addr;
  logic                req_state_wen;
  set_idx_t            req_state_set;
  way_oh_t             req_state_way;
  coh_state_e          req_state_wdata;
  logic                lru_wen;
  set_idx_t            lru_wset;
  lru_t                lru_wdata;
  way_oh_t             fill_way;
  coh_state_e          fill_state;
  logic                pend_valid;
  xact_tag_t           pend_tag;
  way_oh_t             look_way;
  coh_state_e          look_state;
  lru_t                look_lru;
  logic [num_ways-1:0] look_valid_ways;

  assign l2tag_fill_way = fill_way;

  l2tag_req_pipe u_req_pipe (.*);

  l2tag_snoop #(.bus_id(bus_id)) u_snoop (.*);

  l2tag_array u_array (.*);

endmodule

// File: hdl/l2tag_req_pipe.sv
// two-stage request pipeline with miss handling, feeding the L2 data array
`timescale 1ns/1ps

module l2tag_req_pipe
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  req_op_e             req_op,
  input  logic [31:2]         req_addr,
  input  logic [3:0]          req_wmask,
  input  logic [31:0]         req_wdata,
  output logic                l2_req_ready,
  input  logic                l2data_req_ready,
  input  logic                l2trans_valid,
  input  xact_tag_t           l2trans_tag,
  input  logic                snoop_s0_valid,
  input  logic                snp_s1_valid,
  input  logic                fill,
  input  way_oh_t             look_way,
  input  coh_state_e          look_state,
  input  lru_t                look_lru,
  input  logic [num_ways-1:0] look_valid_ways,
  output logic                l2tag_req_valid,
  output req_op_e             l2tag_req_op,
  output logic                l2tag_req_cmd_valid,
  output bus_cmd_e            l2tag_req_cmd,
  output logic [31:3]         l2tag_req_addr,
  output way_oh_t             l2tag_req_way,
  output logic [7:0]          l2tag_req_wmask,
  output logic [63:0]         l2tag_req_wdata,
  output logic                req_lookup_en,
  output line_addr_t          req_s0_addr,
  output logic                req_state_wen,
  output set_idx_t            req_state_set,
  output way_oh_t             req_state_way,
  output coh_state_e          req_state_wdata,
  output logic                lru_wen,
  output set_idx_t            lru_wset,
  output lru_t                lru_wdata,
  output way_oh_t             fill_way,
  output coh_state_e          fill_state,
  output logic                pend_valid,
  output xact_tag_t           pend_tag
);

  typedef enum logic [1:0] {
    ms_idle,
    ms_issue,
    ms_wait
  } miss_e;

  miss_e       miss_st;
  logic        s0_valid;
  req_op_e     s0_op;
  logic [31:2] s0_addr;
  logic [3:0]  s0_wmask;
  logic [31:0] s0_wdata;
  logic        s1_valid;
  req_op_e     s1_op;
  logic [31:3] s1_addr;
  logic [7:0]  s1_wmask;
  logic [63:0] s1_wdata;
  // lookup results kept after the first stage 1 cycle
  logic        s1_stale;
  way_oh_t     s1_way;
  coh_state_e  s1_state;
  lru_t        s1_lru;
  way_oh_t     s1_victim;
  way_oh_t     cur_way;
  coh_state_e  cur_state;
  lru_t        cur_lru;
  way_oh_t     victim_way;
  way_oh_t     fresh_victim;
  way_oh_t     cur_victim;
  logic        s1_wr;
  logic        miss_now;
  logic        fresh_miss;
  logic        cmd_out;
  logic        s0_stall;
  logic        s1_stall;
  logic        s1_done;
  logic        trans_take;

  assign s1_wr     = s1_op[1];
  assign cur_way   = s1_stale ? s1_way : look_way;
  assign cur_state = s1_stale ? s1_state : look_state;
  assign cur_lru   = s1_stale ? s1_lru : look_lru;

  // a write to a shared or forward line refetches into its own way
  assign fresh_victim = (|look_way) ? look_way : victim_way;
  assign cur_victim   = s1_stale ? s1_victim : fresh_victim;

  assign miss_now   = (look_way == '0) |
                      (s1_wr & ((look_state == state_s) | (look_state == state_f)));
  assign fresh_miss = s1_valid & ~s1_stale & miss_now;
  assign cmd_out    = fresh_miss | (miss_st == ms_issue);
  assign s1_stall   = s1_valid & (fresh_miss | (miss_st != ms_idle) | ~l2data_req_ready);
  assign s1_done    = s1_valid & ~s1_stall;
  assign s0_stall   = s0_valid & (snoop_s0_valid | s1_stall);
  assign trans_take = l2trans_valid & ((miss_st == ms_wait) | (cmd_out & l2data_req_ready));

  l2tag_victim u_victim (
    .valid_ways (look_valid_ways),
    .lru        (cur_lru),
    .access_way (cur_way),
    .victim_way (victim_way),
    .next_lru   (lru_wdata)
  );

  assign l2_req_ready  = ~s0_stall;
  assign req_lookup_en = s0_valid & ~snoop_s0_valid & ~s1_stall;
  assign req_s0_addr   = s0_addr[31:6];

  assign l2tag_req_valid     = s1_done | cmd_out;
  assign l2tag_req_cmd_valid = cmd_out;
  assign l2tag_req_op        = cmd_out ? op_rd : s1_op;
  assign l2tag_req_cmd       = s1_wr ? cmd_busrdx : cmd_busrd;
  assign l2tag_req_addr      = s1_addr;
  assign l2tag_req_way       = cmd_out ? cur_victim : cur_way;
  assign l2tag_req_wmask     = s1_wmask;
  assign l2tag_req_wdata     = s1_wdata;

  assign lru_wen         = s1_done;
  assign lru_wset        = set_of(s1_addr[31:6]);
  assign req_state_wen   = s1_done & s1_wr & (cur_state != state_m) & ~snp_s1_valid;
  assign req_state_set   = set_of(s1_addr[31:6]);
  assign req_state_way   = cur_way;
  assign req_state_wdata = state_m;
  assign fill_way        = s1_victim;
  assign fill_state      = s1_wr ? state_m : state_f;

  always_ff @(posedge clk) begin
    if (rst) begin
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
      s1_stale <= 1'b0;
    end else begin
      s1_stale <= s1_stall;
      if (!s0_stall) begin
        s0_valid <= req_valid;
      end
      if (!s1_stall) begin
        s1_valid <= s0_valid & ~snoop_s0_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s0_stall) begin
      s0_op    <= req_op;
      s0_addr  <= req_addr;
      s0_wmask <= req_wmask;
      s0_wdata <= req_wdata;
    end
    if (!s1_stall && s0_valid && !snoop_s0_valid) begin
      s1_op    <= s0_op;
      s1_addr  <= s0_addr[31:3];
      s1_wmask <= s0_addr[2] ? {s0_wmask, 4'b0000} : {4'b0000, s0_wmask};
      s1_wdata <= {2{s0_wdata}};
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && !s1_stale) begin
      s1_way    <= look_way;
      s1_state  <= look_state;
      s1_lru    <= look_lru;
      s1_victim <= fresh_victim;
    end else if (fill) begin
      // completes as a hit on the filled way next cycle
      s1_way   <= s1_victim;
      s1_state <= fill_state;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_st    <= ms_idle;
      pend_valid <= 1'b0;
    end else begin
      case (miss_st)
        ms_idle:  if (fresh_miss) miss_st <= l2data_req_ready ? ms_wait : ms_issue;
        ms_issue: if (l2data_req_ready) miss_st <= ms_wait;
        ms_wait:  if (fill) miss_st <= ms_idle;
        default:  miss_st <= ms_idle;
      endcase
      if (fill) begin
        pend_valid <= 1'b0;
      end else if (trans_take) begin
        pend_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (trans_take) begin
      pend_tag <= l2trans_tag;
    end
  end

endmodule

// File: hdl/l2tag_snoop.sv
// bus snoop stages, fill detection and coherence updates for foreign traffic
`timescale 1ns/1ps

module l2tag_snoop
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
#(
  parameter logic [bus_id_w-1:0] bus_id = 2'd1
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        bus_valid,
  input  bus_cmd_e    bus_cmd,
  input  logic [4:0]  bus_tag,
  input  line_addr_t  bus_addr,
  input  logic [63:0] bus_data,
  input  way_oh_t     look_way,
  input  logic        pend_valid,
  input  xact_tag_t   pend_tag,
  output logic        snoop_s0_valid,
  output line_addr_t  snoop_s0_addr,
  output logic        snp_s1_valid,
  output logic        fill,
  output logic        snp_state_wen,
  output line_addr_t  snp_addr,
  output coh_state_e  snp_state_wdata,
  output logic        l2tag_fill_valid,
  output line_addr_t  l2tag_fill_addr,
  output logic [63:0] l2tag_fill_wdata,
  output logic        l2_bus_hit
);

  bus_cmd_e    s0_cmd;
  logic [4:0]  s0_tag;
  logic [63:0] s0_data;
  bus_cmd_e    s1_cmd;
  logic [4:0]  s1_tag;
  logic [63:0] s1_data;
  logic        accept;
  logic        rd_hit;
  logic        rdx_hit;

  // own traffic is ignored except for fills
  assign accept = bus_valid &
                  ((bus_tag[4 -: bus_id_w] != bus_id) | (bus_cmd == cmd_fill));

  always_ff @(posedge clk) begin
    if (rst) begin
      snoop_s0_valid <= 1'b0;
      snp_s1_valid   <= 1'b0;
      l2_bus_hit     <= 1'b0;
    end else begin
      snoop_s0_valid <= accept;
      snp_s1_valid   <= snoop_s0_valid;
      l2_bus_hit     <= rd_hit | rdx_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s0_cmd        <= bus_cmd;
      s0_tag        <= bus_tag;
      snoop_s0_addr <= bus_addr;
      s0_data       <= bus_data;
    end
    if (snoop_s0_valid) begin
      s1_cmd   <= s0_cmd;
      s1_tag   <= s0_tag;
      snp_addr <= snoop_s0_addr;
      s1_data  <= s0_data;
    end
  end

  assign rd_hit  = snp_s1_valid & (|look_way) & (s1_cmd == cmd_busrd);
  assign rdx_hit = snp_s1_valid & (|look_way) & (s1_cmd == cmd_busrdx);

  // BusRd shares the line, BusRdX takes it away
  assign snp_state_wen   = rd_hit | rdx_hit;
  assign snp_state_wdata = rd_hit ? state_s : state_i;

  assign fill = snp_s1_valid & (s1_cmd == cmd_fill) & pend_valid &
                (s1_tag == {bus_id, pend_tag});

  assign l2tag_fill_valid = fill;
  assign l2tag_fill_addr  = snp_addr;
  assign l2tag_fill_wdata = s1_data;

endmodule

// File: l2tag.f
common/l2_geom_pkg.sv
common/l2_coh_pkg.sv
tag_array/l2tag_victim.sv
tag_array/l2tag_array.sv
hdl/l2tag_req_pipe.sv
hdl/l2tag_snoop.sv
hdl/l2tag.sv
verification/l2tag_sva.sv
verification/l2tag_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the l2tag testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f l2tag.f --top-module l2tag_tb \
  -Mdir obj_dir -o l2tag_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/l2tag_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tag_array/l2tag_array.sv
// tag, state and tree-LRU storage with the shared lookup register and write ports
`timescale 1ns/1ps

module l2tag_array
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                snoop_s0_valid,
  input  line_addr_t          snoop_s0_addr,
  input  logic                req_lookup_en,
  input  line_addr_t          req_s0_addr,
  input  logic                snp_state_wen,
  input  line_addr_t          snp_addr,
  input  coh_state_e          snp_state_wdata,
  input  logic                req_state_wen,
  input  set_idx_t            req_state_set,
  input  way_oh_t             req_state_way,
  input  coh_state_e          req_state_wdata,
  input  logic                fill,
  input  way_oh_t             fill_way,
  input  coh_state_e          fill_state,
  input  logic                lru_wen,
  input  set_idx_t            lru_wset,
  input  lru_t                lru_wdata,
  output way_oh_t             look_way,
  output coh_state_e          look_state,
  output lru_t                look_lru,
  output logic [num_ways-1:0] look_valid_ways
);

  coh_state_e [num_ways-1:0] state_mem [num_sets];
  line_tag_t  [num_ways-1:0] tag_mem   [num_sets];
  lru_t                      lru_mem   [num_sets];

  line_addr_t          look_addr;
  set_idx_t            look_set;
  way_oh_t             hit_way;
  coh_state_e          hit_state;
  logic [num_ways-1:0] valid_ways;
  set_idx_t            st_wset;
  way_oh_t             st_wway;
  coh_state_e          st_wdata;

  // snoops own the lookup port when both want it
  always_comb begin
    look_addr = snoop_s0_valid ? snoop_s0_addr : req_s0_addr;
    look_set  = set_of(look_addr);
    hit_way   = '0;
    hit_state = state_i;
    for (int w = 0; w < num_ways; w++) begin
      valid_ways[w] = state_mem[look_set][w] != state_i;
      if (valid_ways[w] && tag_mem[look_set][w] == tag_of(look_addr)) begin
        hit_way[w] = 1'b1;
        hit_state  = state_mem[look_set][w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (snoop_s0_valid || req_lookup_en) begin
      look_way        <= hit_way;
      look_state      <= hit_state;
      look_valid_ways <= valid_ways;
      // pick up an LRU update landing in the same cycle
      look_lru        <= (lru_wen && lru_wset == look_set) ? lru_wdata : lru_mem[look_set];
    end
  end

  // one state write port, snoop side first
  always_comb begin
    if (snp_state_wen) begin
      st_wset  = set_of(snp_addr);
      st_wway  = look_way;
      st_wdata = snp_state_wdata;
    end else if (fill) begin
      st_wset  = set_of(snp_addr);
      st_wway  = fill_way;
      st_wdata = fill_state;
    end else begin
      st_wset  = req_state_set;
      st_wway  = req_state_way;
      st_wdata = req_state_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < num_sets; s++) begin
        lru_mem[s] <= '0;
        for (int w = 0; w < num_ways; w++) begin
          state_mem[s][w] <= state_i;
        end
      end
    end else begin
      if (snp_state_wen || fill || req_state_wen) begin
        state_mem[st_wset][way_idx(st_wway)] <= st_wdata;
      end
      if (lru_wen) begin
        lru_mem[lru_wset] <= lru_wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[set_of(snp_addr)][way_idx(fill_way)] <= tag_of(snp_addr);
    end
  end

endmodule

// File: tag_array/l2tag_victim.sv
// victim way selection and tree-LRU update, purely combinational
`timescale 1ns/1ps

module l2tag_victim
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
(
  input  logic [num_ways-1:0] valid_ways,
  input  lru_t                lru,
  input  way_oh_t             access_way,
  output way_oh_t             victim_way,
  output lru_t                next_lru
);

  logic [1:0] acc_idx;

  always_comb begin
    if (!(&valid_ways)) begin
      // lowest free way wins
      casez (valid_ways)
        4'b???0: victim_way = 4'b0001;
        4'b??01: victim_way = 4'b0010;
        4'b?011: victim_way = 4'b0100;
        default: victim_way = 4'b1000;
      endcase
    end else if (!lru[2]) begin
      victim_way = lru[0] ? 4'b0010 : 4'b0001;
    end else begin
      victim_way = lru[1] ? 4'b1000 : 4'b0100;
    end
  end

  // point away from the half and the way just used
  assign acc_idx     = way_idx(access_way);
  assign next_lru[2] = ~acc_idx[1];
  assign next_lru[1] = acc_idx[1] ? ~acc_idx[0] : lru[1];
  assign next_lru[0] = acc_idx[1] ? lru[0] : ~acc_idx[0];

endmodule

// File: verification/l2tag_sva.sv
// port-level protocol assertions, bound into the l2tag top level
`timescale 1ns/1ps

module l2tag_sva
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     l2tag_req_valid,
  input logic     l2tag_req_cmd_valid,
  input bus_cmd_e l2tag_req_cmd,
  input way_oh_t  l2tag_req_way,
  input logic     l2_bus_hit
);

  way_onehot: assert property (@(posedge clk) disable iff (rst)
    l2tag_req_valid |-> $onehot0(l2tag_req_way))
    else $error("l2tag_req_way is not one-hot while l2tag_req_valid is high");

  // only read and read-exclusive are ever issued
  cmd_legal: assert property (@(posedge clk) disable iff (rst)
    (l2tag_req_valid && l2tag_req_cmd_valid) |->
      (l2tag_req_cmd == cmd_busrd || l2tag_req_cmd == cmd_busrdx))
    else $error("l2tag_req_cmd is neither BusRd nor BusRdX");

  hit_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !l2_bus_hit)
    else $error("l2_bus_hit high in the cycle after reset");

endmodule

bind l2tag l2tag_sva u_sva (.*);

// File: verification/l2tag_tb.sv
// directed testbench for the L2 tag side, models the request FIFO, bus and transaction unit
`timescale 1ns/1ps

module l2tag_tb
  import l2_geom_pkg::*;
  import l2_coh_pkg::*;
();

  // limit well above the few hundred cycles the tests need
  localparam int cycle_limit = 2000;
  localparam int resp_limit  = 20;
  // set 1, tag 9
  localparam logic [31:0] addr_a = 32'h0004_8040;
  // set 1, tag 17, never filled
  localparam logic [31:0] addr_b = 32'h0008_8040;

  logic        clk;
  logic        rst;
  logic        req_valid;
  req_op_e     req_op;
  logic [31:2] req_addr;
  logic [3:0]  req_wmask;
  logic [31:0] req_wdata;
  logic        l2_req_ready;
  logic        bus_valid;
  bus_cmd_e    bus_cmd;
  logic [4:0]  bus_tag;
  line_addr_t  bus_addr;
  logic [63:0] bus_data;
  logic        l2tag_req_valid;
  req_op_e     l2tag_req_op;
  logic        l2tag_req_cmd_valid;
  bus_cmd_e    l2tag_req_cmd;
  logic [31:3] l2tag_req_addr;
  way_oh_t     l2tag_req_way;
  logic [7:0]  l2tag_req_wmask;
  logic [63:0] l2tag_req_wdata;
  logic        l2data_req_ready;
  logic        l2tag_fill_valid;
  line_addr_t  l2tag_fill_addr;
  way_oh_t     l2tag_fill_way;
  logic [63:0] l2tag_fill_wdata;
  logic        l2trans_valid;
  xact_tag_t   l2trans_tag;
  logic        l2_bus_hit;

  int          value_errors;
  int          other_errors;
  int          cycles;

  l2tag #(.bus_id(2'd1)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    value_errors++;
    $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_other(input string what);
    other_errors++;
    $display("Error: %s at %0t", what, $time);
  endtask

  task automatic finish_run();
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // address in set 5 with tag 0x100 + n
  function automatic logic [31:0] repl_addr(input int n);
    line_tag_t tag;
    tag = line_tag_t'(17'h100 + n);
    return {tag, 9'd5, 6'd0};
  endfunction

  // returns on the falling edge after the request was taken
  task automatic send_req(input req_op_e op, input logic [31:0] addr, input logic [3:0] mask,
                          input logic [31:0] data);
    int n;
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr[31:2];
    req_wmask = mask;
    req_wdata = data;
    n = 0;
    while (!l2_req_ready && n < resp_limit) begin
      @(negedge clk);
      n++;
    end
    if (!l2_req_ready) report_other("request was never accepted");
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // counts falling edges from the taking edge until the data array sees a request
  task automatic wait_resp(output int lat);
    lat = 1;
    while (!l2tag_req_valid && lat < resp_limit) begin
      @(negedge clk);
      lat++;
    end
    if (!l2tag_req_valid) report_other("no request reached the data array");
  endtask

  task automatic check_miss_cmd(input bus_cmd_e cmd, input way_oh_t way,
                                input logic [31:0] addr);
    int lat;
    wait_resp(lat);
    if (lat != 2) report_other($sformatf("miss command after %0d cycles, not 2", lat));
    if (l2tag_req_cmd_valid !== 1'b1)
      report_value("l2tag_req_cmd_valid", l2tag_req_cmd_valid, 1);
    if (l2tag_req_cmd !== cmd) report_value("l2tag_req_cmd", l2tag_req_cmd, cmd);
    if (cmd == cmd_busrd && l2tag_req_op !== op_rd)
      report_value("l2tag_req_op", l2tag_req_op, op_rd);
    if (l2tag_req_way !== way) report_value("l2tag_req_way", l2tag_req_way, way);
    if (l2tag_req_addr !== addr[31:3]) report_value("l2tag_req_addr", l2tag_req_addr, addr[31:3]);
  endtask

  task automatic check_completion(input req_op_e op, input way_oh_t way, input logic [31:0] addr,
                                  input logic [3:0] mask, input logic [31:0] data);
    logic [7:0] lane_mask;
    // odd word lands in the upper byte lanes
    lane_mask = 8'(mask) << (addr[2] ? 4 : 0);
    if (l2tag_req_cmd_valid !== 1'b0)
      report_value("l2tag_req_cmd_valid", l2tag_req_cmd_valid, 0);
    if (l2tag_req_op !== op) report_value("l2tag_req_op", l2tag_req_op, op);
    if (l2tag_req_way !== way) report_value("l2tag_req_way", l2tag_req_way, way);
    if (l2tag_req_addr !== addr[31:3]) report_value("l2tag_req_addr", l2tag_req_addr, addr[31:3]);
    if (op == op_wr) begin
      if (l2tag_req_wmask !== lane_mask) report_value("l2tag_req_wmask", l2tag_req_wmask, lane_mask);
      if (l2tag_req_wdata !== {data, data}) report_value("l2tag_req_wdata", l2tag_req_wdata, {data, data});
    end
  endtask

  // transaction unit hands out a tag, then the bus returns the line
  task automatic complete_miss(input logic [31:0] addr, input way_oh_t way);
    xact_tag_t   tag;
    logic [63:0] data;
    int          n;
    tag  = xact_tag_t'($urandom);
    data = {$urandom, $urandom};
    l2data_req_ready = 1'b1;
    @(negedge clk);
    l2trans_valid = 1'b1;
    l2trans_tag   = tag;
    @(negedge clk);
    l2trans_valid = 1'b0;
    bus_valid = 1'b1;
    bus_cmd   = cmd_fill;
    bus_tag   = {2'd1, tag};
    bus_addr  = addr[31:6];
    bus_data  = data;
    @(negedge clk);
    bus_valid = 1'b0;
    n = 0;
    while (!l2tag_fill_valid && n < resp_limit) begin
      if (l2tag_req_valid) report_other("request output active while the miss waits for fill");
      @(negedge clk);
      n++;
    end
    if (!l2tag_fill_valid) begin
      report_other("fill never reached the data array");
    end else begin
      if (l2tag_fill_addr !== addr[31:6]) report_value("l2tag_fill_addr", l2tag_fill_addr, addr[31:6]);
      if (l2tag_fill_way !== way) report_value("l2tag_fill_way", l2tag_fill_way, way);
      if (l2tag_fill_wdata !== data) report_value("l2tag_fill_wdata", l2tag_fill_wdata, data);
    end
    @(negedge clk);
    if (!l2tag_req_valid) report_other("request did not complete the cycle after fill");
  endtask

  task automatic run_miss(input req_op_e op, input logic [31:0] addr, input logic [3:0] mask,
                          input logic [31:0] data, input way_oh_t way);
    bus_cmd_e cmd;
    cmd = (op == op_wr) ? cmd_busrdx : cmd_busrd;
    send_req(op, addr, mask, data);
    check_miss_cmd(cmd, way, addr);
    complete_miss(addr, way);
    check_completion(op, way, addr, mask, data);
  endtask

  task automatic run_hit(input req_op_e op, input logic [31:0] addr, input logic [3:0] mask,
                         input logic [31:0] data, input way_oh_t way);
    int lat;
    send_req(op, addr, mask, data);
    wait_resp(lat);
    if (lat != 2) report_other($sformatf("hit completed after %0d cycles, not 2", lat));
    check_completion(op, way, addr, mask, data);
  endtask

  // hit pulse must show on the third falling edge after the bus is sampled
  task automatic snoop_and_check(input bus_cmd_e cmd, input logic [1:0] id,
                                 input logic [31:0] addr, input logic hit);
    @(negedge clk);
    bus_valid = 1'b1;
    bus_cmd   = cmd;
    bus_tag   = {id, 3'd0};
    bus_addr  = addr[31:6];
    @(negedge clk);
    bus_valid = 1'b0;
    for (int k = 1; k <= 4; k++) begin
      if (k > 1) @(negedge clk);
      if (l2_bus_hit !== (hit && k == 3)) report_value("l2_bus_hit", l2_bus_hit, hit && k == 3);
    end
  endtask

  task automatic test_read_miss_fill();
    run_miss(op_rd, addr_a, 4'h0, 32'h0, 4'b0001);
  endtask

  task automatic test_read_hit();
    run_hit(op_rd, addr_a, 4'h0, 32'h0, 4'b0001);
  endtask

  task automatic test_write();
    run_miss(op_wr, addr_a, 4'b0011, $urandom, 4'b0001);
    run_hit(op_wr, addr_a | 32'h4, 4'b1010, $urandom, 4'b0001);
  endtask

  task automatic test_snoop();
    snoop_and_check(cmd_busrd, 2'd2, addr_a, 1'b1);
    run_miss(op_wr, addr_a, 4'hf, $urandom, 4'b0001);
    snoop_and_check(cmd_busrdx, 2'd3, addr_a, 1'b1);
    run_miss(op_rd, addr_a, 4'h0, 32'h0, 4'b0001);
    snoop_and_check(cmd_busrd, 2'd0, addr_b, 1'b0);
    snoop_and_check(cmd_busrd, 2'd1, addr_a, 1'b0);
    run_hit(op_rd, addr_a, 4'h0, 32'h0, 4'b0001);
  endtask

  task automatic test_replacement();
    way_oh_t exp_way [5];
    // free ways fill in order before the tree bits pick way 0 again
    exp_way = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0001};
    for (int i = 1; i <= 5; i++) begin
      run_miss(op_rd, repl_addr(i), 4'h0, 32'h0, exp_way[i-1]);
    end
  endtask

  // tags 0x102 and 0x103 landed in ways 1 and 2 during replacement
  task automatic test_backpressure();
    if (!l2_req_ready) report_other("pipeline not empty before the back-pressure test");
    @(negedge clk);
    l2data_req_ready = 1'b0;
    req_valid = 1'b1;
    req_op    = op_rd;
    req_addr  = 30'(repl_addr(2) >> 2);
    req_wmask = 4'h0;
    @(negedge clk);
    if (!l2_req_ready) report_other("second request refused while stage 1 was empty");
    req_addr = 30'(repl_addr(3) >> 2);
    @(negedge clk);
    req_valid = 1'b0;
    repeat (4) begin
      if (l2_req_ready !== 1'b0) report_value("l2_req_ready", l2_req_ready, 0);
      @(negedge clk);
    end
    l2data_req_ready = 1'b1;
    #1;
    if (!l2tag_req_valid) report_other("first queued request not delivered on release");
    else check_completion(op_rd, 4'b0010, repl_addr(2), 4'h0, 32'h0);
    @(negedge clk);
    if (!l2tag_req_valid) report_other("second queued request not delivered");
    else check_completion(op_rd, 4'b0100, repl_addr(3), 4'h0, 32'h0);
    @(negedge clk);
    if (!l2_req_ready) report_other("l2_req_ready stayed low after the queue drained");
  endtask

  initial begin
    void'($urandom(32'h6b312936));
    value_errors     = 0;
    other_errors     = 0;
    rst              = 1'b1;
    req_valid        = 1'b0;
    req_op           = op_rd;
    req_addr         = '0;
    req_wmask        = '0;
    req_wdata        = '0;
    bus_valid        = 1'b0;
    bus_cmd          = cmd_busrd;
    bus_tag          = '0;
    bus_addr         = '0;
    bus_data         = '0;
    l2data_req_ready = 1'b1;
    l2trans_valid    = 1'b0;
    l2trans_tag      = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    if (l2_req_ready !== 1'b1) report_value("l2_req_ready", l2_req_ready, 1);
    if (l2tag_req_valid !== 1'b0) report_value("l2tag_req_valid", l2tag_req_valid, 0);
    if (l2tag_fill_valid !== 1'b0) report_value("l2tag_fill_valid", l2tag_fill_valid, 0);
    if (l2_bus_hit !== 1'b0) report_value("l2_bus_hit", l2_bus_hit, 0);
    test_read_miss_fill();
    test_read_hit();
    test_write();
    test_snoop();
    test_replacement();
    test_backpressure();
    finish_run();
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    report_other($sformatf("run did not finish within %0d cycles", cycle_limit));
    finish_run();
  end

endmodule
